// File: hw/cpuPkg.sv
package cpuPkg;

  //////////////////////////////////////////////////////////////////////
  // Widths that carry a meaning
  //////////////////////////////////////////////////////////////////////
  typedef logic [15:0] wordT;    // Data word and byte address
  typedef logic [3:0]  regIdxT;  // Register number, r0 reads as zero
  typedef logic [2:0]  flagsT;   // Packed as {Z, V, N}
  typedef logic [3:0]  opcodeT;  // Instruction bits 15:12
  typedef logic [2:0]  condT;    // Branch condition, bits 11:9

  // Bit positions inside flagsT
  localparam int FlagZ = 2;
  localparam int FlagV = 1;
  localparam int FlagN = 0;

  //////////////////////////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////////////////////////
  localparam opcodeT OpAdd = 4'b0000;  // Saturating add
  localparam opcodeT OpSub = 4'b0001;  // Saturating subtract
  localparam opcodeT OpXor = 4'b0010;
  localparam opcodeT OpLw  = 4'b1000;  // rd = mem[rs + 2*off]
  localparam opcodeT OpSw  = 4'b1001;  // mem[rs + 2*off] = rd
  localparam opcodeT OpLlb = 4'b1010;  // rd = sext(imm8)
  localparam opcodeT OpB   = 4'b1100;  // Conditional, pc-relative
  localparam opcodeT OpHlt = 4'b1111;

  // Branch conditions, tested against the stored flags
  localparam condT CondNe = 3'b000;
  localparam condT CondEq = 3'b001;
  localparam condT CondGt = 3'b010;
  localparam condT CondLt = 3'b011;
  localparam condT CondGe = 3'b100;
  localparam condT CondLe = 3'b101;
  localparam condT CondOv = 3'b110;
  localparam condT CondAl = 3'b111;  // Unconditional

  // Unified memory depth in 16-bit words
  localparam int MemWords = 256;

endpackage

// File: hw/ctrlBus.sv
`timescale 1ns/1ns

interface ctrlBus;

  logic irLoad;    // Capture instruction at pc
  logic opLatch;   // Capture register operands
  logic aluLoad;   // Result register, flags on ADD/SUB/XOR
  logic memWrite;  // Data port store
  logic memRead;   // Data port load, data valid next cycle
  logic regWrite;  // Write-back into rd
  logic pcStep;    // pc + 2
  logic pcLoad;    // pc = branch target
  logic memToReg;  // Write-back source is memory
  logic brTaken;   // Branch condition status from the ALU

  // Sequencer side
  modport ctrl (output irLoad, opLatch, aluLoad, memWrite, memRead,
                output regWrite, pcStep, pcLoad, memToReg, input brTaken);

  // Datapath side, strobes only
  modport dp (input irLoad, opLatch, aluLoad, memWrite, memRead,
              input regWrite, pcStep, pcLoad, memToReg);

endinterface

// File: hw/cpuCtrl.sv
`timescale 1ns/1ns

module cpuCtrl (
  input  logic           clk,
  input  logic           rstN,
  input  cpuPkg::opcodeT opcode,  // From the instruction register
  ctrlBus.ctrl           bus,
  output logic           hlt
);

  typedef enum logic [2:0] {
    Fetch, Decode, Execute, Memory, WriteBack, Halt
  } stateT;

  stateT state;
  stateT nextState;
  logic  isLw;
  logic  isSw;
  logic  isBr;
  logic  writesReg;  // Opcode that ends with a register write

  assign isLw      = (opcode == cpuPkg::OpLw);
  assign isSw      = (opcode == cpuPkg::OpSw);
  assign isBr      = (opcode == cpuPkg::OpB);
  assign writesReg = (opcode == cpuPkg::OpAdd) || (opcode == cpuPkg::OpSub) ||
                     (opcode == cpuPkg::OpXor) || (opcode == cpuPkg::OpLlb) || isLw;

  always_ff @(posedge clk) begin
    if (!rstN) state <= Fetch;
    else       state <= nextState;
  end

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    nextState = state;
    case (state)
      Fetch:     nextState = Decode;
      Decode:    nextState = (opcode == cpuPkg::OpHlt) ? Halt : Execute;
      Execute: begin
        if (isBr)              nextState = Fetch;      // Branch resolves here
        else if (isLw || isSw) nextState = Memory;
        else                   nextState = WriteBack;
      end
      Memory:    nextState = isLw ? WriteBack : Fetch;  // SW is done after the store
      WriteBack: nextState = Fetch;
      Halt:      nextState = Halt;                      // Left only by reset
      default:   nextState = Fetch;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Strobes, one clock each in their state
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    bus.irLoad   = 1'b0;
    bus.opLatch  = 1'b0;
    bus.aluLoad  = 1'b0;
    bus.memWrite = 1'b0;
    bus.memRead  = 1'b0;
    bus.regWrite = 1'b0;
    bus.pcStep   = 1'b0;
    bus.pcLoad   = 1'b0;
    bus.memToReg = 1'b0;
    case (state)
      Fetch:  bus.irLoad  = 1'b1;
      Decode: bus.opLatch = 1'b1;
      Execute: begin
        if (isBr) begin
          bus.pcLoad = bus.brTaken;   // Jump
          bus.pcStep = !bus.brTaken;  // Fall through
        end else begin
          bus.aluLoad = 1'b1;         // Result or address
        end
      end
      Memory: begin
        bus.memRead  = isLw;
        bus.memWrite = isSw;
        bus.pcStep   = isSw;
      end
      WriteBack: begin
        bus.regWrite = writesReg;     // Unused opcodes behave as no-ops
        bus.memToReg = isLw;
        bus.pcStep   = 1'b1;
      end
      default: ;
    endcase
  end

  assign hlt = (state == Halt);

endmodule

// File: hw/pcCounter.sv
`timescale 1ns/1ns

module pcCounter (
  input  logic         clk,
  input  logic         rstN,
  ctrlBus.dp           bus,
  input  cpuPkg::wordT target,  // Branch destination
  output cpuPkg::wordT pc
);

  cpuPkg::wordT pcPlus2;

  assign pcPlus2 = pc + 16'd2;  // Word-aligned step

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= '0;               // Program starts at address 0
    end else if (bus.pcLoad) begin
      pc <= target;           // Taken branch
    end else if (bus.pcStep) begin
      pc <= pcPlus2;
    end
  end

endmodule

// File: hw/regFile.sv
`timescale 1ns/1ns

module regFile (
  input  logic           clk,
  input  logic           rstN,
  ctrlBus.dp             bus,
  input  cpuPkg::regIdxT rsIdx,
  input  cpuPkg::regIdxT rtIdx,   // rd for SW
  input  cpuPkg::regIdxT rdIdx,
  input  cpuPkg::wordT   wrData,
  output cpuPkg::wordT   rsData,  // Held from opLatch onward
  output cpuPkg::wordT   rtData
);

  cpuPkg::wordT regs [2**$bits(cpuPkg::regIdxT)];

  // Write port, r0 is never written
  always_ff @(posedge clk) begin
    if (bus.regWrite && (rdIdx != '0)) regs[rdIdx] <= wrData;
  end

  // Operand latches, r0 reads as zero
  always_ff @(posedge clk) begin
    if (!rstN) begin
      rsData <= '0;
      rtData <= '0;
    end else if (bus.opLatch) begin
      rsData <= (rsIdx == '0) ? '0 : regs[rsIdx];
      rtData <= (rtIdx == '0) ? '0 : regs[rtIdx];
    end
  end

endmodule

// File: hw/aluUnit.sv
`timescale 1ns/1ns

module aluUnit (
  input  logic           clk,
  input  logic           rstN,
  ctrlBus.dp             bus,
  input  cpuPkg::opcodeT opcode,
  input  cpuPkg::condT   cond,
  input  cpuPkg::wordT   opA,     // rs
  input  cpuPkg::wordT   opB,     // rt
  input  cpuPkg::wordT   imm,     // LLB byte or scaled LW/SW offset
  output cpuPkg::wordT   result,
  output logic           taken    // Branch condition holds
);

  cpuPkg::wordT  sum;
  cpuPkg::wordT  diff;
  cpuPkg::wordT  satVal;
  cpuPkg::wordT  aluOut;
  cpuPkg::flagsT flags;     // {Z, V, N}
  logic          addOvf;
  logic          subOvf;
  logic          zero;

  assign sum    = opA + opB;
  assign diff   = opA - opB;
  assign addOvf = (opA[15] == opB[15]) && (sum[15] != opA[15]);   // Same signs in, sign flips
  assign subOvf = (opA[15] != opB[15]) && (diff[15] != opA[15]);
  assign satVal = opA[15] ? 16'h8000 : 16'h7fff;  // Clamp toward the sign of opA

  always_comb begin
    case (opcode)
      cpuPkg::OpAdd: aluOut = addOvf ? satVal : sum;
      cpuPkg::OpSub: aluOut = subOvf ? satVal : diff;
      cpuPkg::OpXor: aluOut = opA ^ opB;
      cpuPkg::OpLlb: aluOut = imm;
      default:       aluOut = opA + imm;  // LW/SW effective address
    endcase
  end

  assign zero = (aluOut == '0);

  always_ff @(posedge clk) begin
    if (bus.aluLoad) result <= aluOut;
  end

  //////////////////////////////////////////////////////////////////////
  // Flag register
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= '0;
    end else if (bus.aluLoad) begin
      case (opcode)
        cpuPkg::OpAdd: flags <= {zero, addOvf, aluOut[15]};
        cpuPkg::OpSub: flags <= {zero, subOvf, aluOut[15]};
        cpuPkg::OpXor: flags[cpuPkg::FlagZ] <= zero;  // V and N kept
        default: ;
      endcase
    end
  end

  // Condition against stored flags
  always_comb begin
    case (cond)
      cpuPkg::CondNe: taken = !flags[cpuPkg::FlagZ];
      cpuPkg::CondEq: taken = flags[cpuPkg::FlagZ];
      cpuPkg::CondGt: taken = !flags[cpuPkg::FlagZ] && !flags[cpuPkg::FlagN];
      cpuPkg::CondLt: taken = flags[cpuPkg::FlagN];
      cpuPkg::CondGe: taken = flags[cpuPkg::FlagZ] || !flags[cpuPkg::FlagN];
      cpuPkg::CondLe: taken = flags[cpuPkg::FlagZ] || flags[cpuPkg::FlagN];
      cpuPkg::CondOv: taken = flags[cpuPkg::FlagV];
      default:        taken = 1'b1;  // AL
    endcase
  end

endmodule

// File: hw/cpuMem.sv
`timescale 1ns/1ns

module cpuMem (
  input  logic         clk,
  ctrlBus.dp           bus,
  input  cpuPkg::wordT instAddr,  // Byte address, from pc
  input  cpuPkg::wordT dataAddr,  // Byte address, from the ALU
  input  cpuPkg::wordT wrData,
  output cpuPkg::wordT inst,      // Combinational
  output cpuPkg::wordT rdData     // Valid the cycle after memRead
);

  logic [$clog2(cpuPkg::MemWords)-1:0] instIdx;
  logic [$clog2(cpuPkg::MemWords)-1:0] dataIdx;

  cpuPkg::wordT memArray [cpuPkg::MemWords];  // Program and data share one array

  // Word index, address bit 0 dropped
  assign instIdx = instAddr[$clog2(cpuPkg::MemWords):1];
  assign dataIdx = dataAddr[$clog2(cpuPkg::MemWords):1];

  assign inst = memArray[instIdx];  // Instruction port

  //////////////////////////////////////////////////////////////////////
  // Data port
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (bus.memWrite) memArray[dataIdx] <= wrData;
  end

  always_ff @(posedge clk) begin
    if (bus.memRead) rdData <= memArray[dataIdx];
  end

endmodule

// File: hw/cpuModel.sv
`timescale 1ns/1ns

module cpuModel (
  input  logic         clk,
  input  logic         rstN,  // Synchronous, active low
  output logic         hlt,   // High from the cycle after HLT decode
  output cpuPkg::wordT pc
);

  ctrlBus bus ();

  cpuPkg::wordT   inst;       // Word at pc
  cpuPkg::wordT   ir;         // Instruction register
  cpuPkg::opcodeT opcode;
  cpuPkg::condT   cond;
  cpuPkg::regIdxT rdIdx;
  cpuPkg::regIdxT rsIdx;
  cpuPkg::regIdxT rtIdx;      // Second read index, rd on SW
  cpuPkg::wordT   llbImm;
  cpuPkg::wordT   memOff;
  cpuPkg::wordT   aluImm;
  cpuPkg::wordT   brTarget;
  cpuPkg::wordT   rsData;
  cpuPkg::wordT   rtData;
  cpuPkg::wordT   aluResult;
  cpuPkg::wordT   memRdData;
  cpuPkg::wordT   wbData;
  logic           taken;

  always_ff @(posedge clk) begin
    if (!rstN)           ir <= '0;
    else if (bus.irLoad) ir <= inst;
  end

  //////////////////////////////////////////////////////////////////////
  // Decode fields and immediates
  //////////////////////////////////////////////////////////////////////
  assign opcode = ir[15:12];
  assign rdIdx  = ir[11:8];
  assign rsIdx  = ir[7:4];
  assign rtIdx  = (opcode == cpuPkg::OpSw) ? ir[11:8] : ir[3:0];  // Store data comes from rd
  assign cond   = ir[11:9];

  assign llbImm = {{8{ir[7]}}, ir[7:0]};          // Sign-extended byte
  assign memOff = {{11{ir[3]}}, ir[3:0], 1'b0};   // Word offset in bytes
  assign aluImm = (opcode == cpuPkg::OpLlb) ? llbImm : memOff;

  // pc still holds the branch address during EXECUTE
  assign brTarget = pc + 16'd2 + {{6{ir[8]}}, ir[8:0], 1'b0};

  assign wbData = bus.memToReg ? memRdData : aluResult;  // LW or ALU/LLB

  assign bus.brTaken = taken;  // Status back to the sequencer

  //////////////////////////////////////////////////////////////////////
  // Instances
  //////////////////////////////////////////////////////////////////////
  cpuCtrl uCtrl (.clk(clk), .rstN(rstN), .opcode(opcode), .bus(bus.ctrl), .hlt(hlt));

  pcCounter uPc (.clk(clk), .rstN(rstN), .bus(bus.dp), .target(brTarget), .pc(pc));

  regFile uRegs (
    .clk(clk), .rstN(rstN), .bus(bus.dp),
    .rsIdx(rsIdx), .rtIdx(rtIdx), .rdIdx(rdIdx),
    .wrData(wbData), .rsData(rsData), .rtData(rtData)
  );

  aluUnit uAlu (
    .clk(clk), .rstN(rstN), .bus(bus.dp),
    .opcode(opcode), .cond(cond), .opA(rsData), .opB(rtData), .imm(aluImm),
    .result(aluResult), .taken(taken)
  );

  cpuMem uMem (
    .clk(clk), .bus(bus.dp),
    .instAddr(pc), .dataAddr(aluResult), .wrData(rtData),  // rtData is rd on SW
    .inst(inst), .rdData(memRdData)
  );

endmodule

// File: tb/cpuModelTb.sv
`timescale 1ns/1ns

module cpuModelTb;

  localparam string ImageFile  = "tb/program.hex";
  localparam int    Seed       = 78;
  localparam int    HaltLimit  = 400;  // Cycles allowed for one run to reach HLT
  localparam int    HoldCycles = 20;   // Cycles pc must hold after hlt

  logic         clk;
  logic         rstN;
  logic         hlt;
  cpuPkg::wordT pc;

  //////////////////////////////////////////////////////////////////////
  // Instruction-level model state
  //////////////////////////////////////////////////////////////////////
  cpuPkg::wordT mMem [cpuPkg::MemWords];            // Own copy of the image
  cpuPkg::wordT mRegs [2**$bits(cpuPkg::regIdxT)];
  logic         mZ;
  logic         mV;
  logic         mN;
  logic         mHalted;
  cpuPkg::wordT mNextPc;   // Where pc goes when the current instruction ends
  int           mCycles;   // Expected length of the current instruction

  // Observations are updated on the falling edge and checked on the rising one
  logic         started = 1'b0;
  logic         checkOn = 1'b0;
  logic         pcEvent = 1'b0;
  cpuPkg::wordT lastPc;
  cpuPkg::wordT obsPc;
  cpuPkg::wordT wantPc;
  int           cyc;        // Falling edges seen at the current pc
  int           obsCycles;
  int           wantCycles;
  logic         obsHlt;
  logic         wantHlt;

  cpuModel dut (.clk(clk), .rstN(rstN), .hlt(hlt), .pc(pc));

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic reportMismatch(input string name, input int got, input int want);
    $display("CHECK FAILED at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
    $display("TB FAILED");
    $fatal(1, "run stopped");
  endtask

  function automatic cpuPkg::wordT readReg(input cpuPkg::regIdxT idx);
    if (idx == '0) return '0;  // r0 always reads zero
    else return mRegs[idx];
  endfunction

  task automatic writeReg(input cpuPkg::regIdxT idx, input cpuPkg::wordT val);
    if (idx != '0) mRegs[idx] = val;
  endtask

  // Byte address to word slot
  function automatic logic [$clog2(cpuPkg::MemWords)-1:0] wordIdx(input cpuPkg::wordT addr);
    return addr[$clog2(cpuPkg::MemWords):1];
  endfunction

  function automatic logic condHolds(input cpuPkg::condT c);
    case (c)
      cpuPkg::CondNe: return !mZ;
      cpuPkg::CondEq: return mZ;
      cpuPkg::CondGt: return !mZ && !mN;
      cpuPkg::CondLt: return mN;
      cpuPkg::CondGe: return mZ || !mN;
      cpuPkg::CondLe: return mZ || mN;
      cpuPkg::CondOv: return mV;
      default:        return 1'b1;  // Always
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Execute one instruction in the model
  //////////////////////////////////////////////////////////////////////
  task automatic stepModel(input cpuPkg::wordT at);
    cpuPkg::wordT ins;
    cpuPkg::wordT a;
    cpuPkg::wordT b;
    cpuPkg::wordT res;
    cpuPkg::wordT addr;
    int           sa;
    int           sb;
    int           s;
    ins     = mMem[wordIdx(at)];
    a       = readReg(ins[7:4]);
    b       = readReg(ins[3:0]);
    addr    = a + {{11{ins[3]}}, ins[3:0], 1'b0};  // rs + 2 * signed offset
    sa      = int'($signed(a));
    sb      = int'($signed(b));
    mNextPc = at + 16'd2;
    mCycles = 4;                                   // ALU and LLB
    case (ins[15:12])
      cpuPkg::OpAdd, cpuPkg::OpSub: begin
        s = (ins[15:12] == cpuPkg::OpAdd) ? sa + sb : sa - sb;
        if (s > 32767) res = 16'h7fff;             // Clamp positive
        else if (s < -32768) res = 16'h8000;       // Clamp negative
        else res = s[15:0];
        mV = (s > 32767) || (s < -32768);
        mZ = (res == 16'h0000);
        mN = res[15];
        writeReg(ins[11:8], res);
      end
      cpuPkg::OpXor: begin
        res = a ^ b;
        mZ  = (res == 16'h0000);                   // V and N keep their value
        writeReg(ins[11:8], res);
      end
      cpuPkg::OpLlb: writeReg(ins[11:8], {{8{ins[7]}}, ins[7:0]});
      cpuPkg::OpLw: begin
        mCycles = 5;
        writeReg(ins[11:8], mMem[wordIdx(addr)]);
      end
      cpuPkg::OpSw: mMem[wordIdx(addr)] = readReg(ins[11:8]);
      cpuPkg::OpB: begin
        mCycles = 3;
        if (condHolds(ins[11:9])) mNextPc = at + 16'd2 + {{6{ins[8]}}, ins[8:0], 1'b0};
      end
      cpuPkg::OpHlt: begin
        mHalted = 1'b1;
        mNextPc = at;                              // pc never moves again
      end
      default: ;
    endcase
  endtask

  //////////////////////////////////////////////////////////////////////
  // Observe the DUT mid-cycle
  //////////////////////////////////////////////////////////////////////
  always @(negedge clk) begin
    pcEvent = 1'b0;
    if (!rstN) begin
      started = 1'b0;
      mZ      = 1'b0;
      mV      = 1'b0;
      mN      = 1'b0;
      mHalted = 1'b0;
    end else if (!started || pc !== lastPc) begin
      pcEvent    = 1'b1;
      obsPc      = pc;
      obsCycles  = started ? cyc : 0;
      wantPc     = started ? mNextPc : 16'h0000;  // Reset vector
      wantCycles = started ? mCycles : 0;
      started    = 1'b1;
      lastPc     = pc;
      cyc        = 1;
      stepModel(wantPc);
    end else begin
      cyc++;
    end
    obsHlt  = hlt;
    wantHlt = mHalted && (cyc >= 3);  // HALT comes after FETCH and DECODE
    checkOn = rstN && started;
  end

  pcFollowsModel: assert property (@(posedge clk) (checkOn && pcEvent) |-> (obsPc == wantPc))
    else reportMismatch("pc", int'(obsPc), int'(wantPc));

  cyclesPerClass: assert property (@(posedge clk)
      (checkOn && pcEvent) |-> (obsCycles == wantCycles))
    else reportMismatch("cycles between pc changes", obsCycles, wantCycles);

  hltFollowsModel: assert property (@(posedge clk) checkOn |-> (obsHlt == wantHlt))
    else reportMismatch("hlt", int'(obsHlt), int'(wantHlt));

  task automatic waitForHalt(input int limit);
    int n;
    n = 0;
    while (hlt !== 1'b1) begin
      if (n == limit) abortRun("Timeout, hlt never rose");
      else begin
        @(negedge clk);
        n++;
      end
    end
  endtask

  initial begin
    int gap;
    int hold;
    void'($urandom(Seed));
    rstN = 1'b0;
    $readmemh(ImageFile, dut.uMem.memArray);
    $readmemh(ImageFile, mMem);
    repeat (4) @(posedge clk);
    #2;
    rstN = 1'b1;
    waitForHalt(HaltLimit);
    repeat (HoldCycles) @(posedge clk);  // pc and hlt watched by the checks

    // Idle a random while and then reset out of HALT
    gap  = $urandom_range(2, 8);
    hold = 4 + $urandom_range(0, 2);
    repeat (gap) @(posedge clk);
    #2;
    rstN = 1'b0;
    repeat (hold) @(posedge clk);
    #2;
    rstN = 1'b1;
    waitForHalt(HaltLimit);
    repeat (HoldCycles) @(posedge clk);

    $display("TB PASSED");
    $finish;
  end

endmodule

// File: tb/program.hex
// One 16-bit word per line in hex, loaded from word address 0
// An @ line moves to a new word address, data sits at byte 0x40
A103 // 00 LLB r1, 3         loop count
A201 // 02 LLB r2, 1
1112 // 04 SUB r1, r1, r2
C1FE // 06 BNE 04            taken twice, then falls through
A640 // 08 LLB r6, 0x40      data base
8360 // 0A LW  r3, 0(r6)     r3 = 7FF0
0533 // 0C ADD r5, r3, r3    saturates to 7FFF, V set
CC01 // 0E BOV 12            taken
A9EE // 10 LLB r9, EE        skipped
C401 // 12 BGT 16            taken
A9EE // 14 LLB r9, EE        skipped
CA01 // 16 BLE 1A            not taken
9561 // 18 SW  r5, 1(r6)     mem[0x42] = 7FFF
8761 // 1A LW  r7, 1(r6)
2875 // 1C XOR r8, r7, r5    zero, Z set
C201 // 1E BEQ 22            taken
A9EE // 20 LLB r9, EE        skipped
F000 // 22 HLT
@20
7FF0 // 40 operand for the saturating add

// File: cpuModel.f
hw/cpuPkg.sv
hw/ctrlBus.sv
hw/cpuCtrl.sv
hw/pcCounter.sv
hw/regFile.sv
hw/aluUnit.sv
hw/cpuMem.sv
hw/cpuModel.sv
tb/cpuModelTb.sv

// File: Makefile
# Verilator build and run for the cpuModel testbench

VERILATOR ?= verilator
TOP       ?= cpuModelTb
FILELIST  ?= cpuModel.f
OBJDIR    ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

SIM := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Exit status of the simulation is the pass or fail result
run: compile
	./$(SIM)

clean:
	rm -rf $(OBJDIR)
